/* list.f */
+incdir+common
common/core_pkg.sv
div/div_unit.sv
hdl/pipe_control.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/core_top.sv
bench/core_props.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: core
  authors: []

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - div/div_unit.sv
      - hdl/pipe_control.sv
      - hdl/decode_stage.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/core_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - bench/core_props.sv
      - bench/core_tb.sv

/* bench/core_tb.sv */
//////////////////////////////
// core testbench, fixed program then random
// instructions, core_props does the checking
//////////////////////////////
`include "core_cfg.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT   = 200;
    localparam int RANDOM_COUNT = 200;

    logic              clk;
    logic              rst;
    logic              instr_req;
    core_pkg::instr_u  instr;
    logic              instr_ack;
    core_pkg::retire_t retire;
    core_pkg::instr_u  prog [$];

    core_top UUT (
        .clk         (clk),
        .rst         (rst),
        .instr_req_i (instr_req),
        .instr_i     (instr),
        .instr_ack_o (instr_ack),
        .retire_o    (retire)
    );

    bind core_top core_props u_props (
        .clk         (clk),
        .rst         (rst),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_i (instr_ack_o),
        .ex_busy_i   (ex_busy),
        .retire_i    (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (UUT.u_props.fail_seen) begin
            $display("Something failed");
            $fatal(1, "stopping at the first failed check");
        end
    end

    function automatic core_pkg::instr_u r_op(input logic [5:0] fn, input int rd,
                                               input int rs, input int rt);
        core_pkg::instr_u w;
        w          = '0;
        w.r.opcode = `CORE_OP_SPECIAL;
        w.r.rs     = rs[`CORE_REG_AW-1:0];
        w.r.rt     = rt[`CORE_REG_AW-1:0];
        w.r.rd     = rd[`CORE_REG_AW-1:0];
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic core_pkg::instr_u i_op(input logic [5:0] op, input int rt,
                                               input int rs, input logic [15:0] imm);
        core_pkg::instr_u w;
        w          = '0;
        w.i.opcode = op;
        w.i.rs     = rs[`CORE_REG_AW-1:0];
        w.i.rt     = rt[`CORE_REG_AW-1:0];
        w.i.imm16  = imm;
        return w;
    endfunction

    // small register range so neighbours depend on each other
    function automatic core_pkg::instr_u random_instr();
        int          sel;
        int          rd;
        int          rs;
        int          rt;
        logic [15:0] imm;
        sel = $urandom_range(13, 0);
        rd  = $urandom_range(7, 0);
        rs  = $urandom_range(7, 0);
        rt  = $urandom_range(7, 0);
        imm = 16'($urandom);
        case (sel)
            0:  return r_op(`CORE_FN_ADDU, rd, rs, rt);
            1:  return r_op(`CORE_FN_SUBU, rd, rs, rt);
            2:  return r_op(`CORE_FN_AND, rd, rs, rt);
            3:  return r_op(`CORE_FN_OR, rd, rs, rt);
            4:  return r_op(`CORE_FN_XOR, rd, rs, rt);
            5:  return r_op(`CORE_FN_SLT, rd, rs, rt);
            6:  return r_op(`CORE_FN_SLTU, rd, rs, rt);
            7:  return r_op(`CORE_FN_DIV, 0, rs, rt);
            8:  return r_op(`CORE_FN_DIVU, 0, rs, rt);
            9:  return r_op(`CORE_FN_MFHI, rd, 0, 0);
            10: return r_op(`CORE_FN_MFLO, rd, 0, 0);
            11: return i_op(`CORE_OP_ADDIU, rt, rs, imm);
            12: return i_op(`CORE_OP_ORI, rt, rs, imm);
            default: return i_op(`CORE_OP_LUI, rt, 0, imm);
        endcase
    endfunction

    task automatic load_program();
        prog.push_back(i_op(`CORE_OP_LUI, 1, 0, 16'h8000));
        prog.push_back(i_op(`CORE_OP_ORI, 1, 1, 16'h0001));
        prog.push_back(i_op(`CORE_OP_ADDIU, 2, 0, 16'hfff9));
        prog.push_back(i_op(`CORE_OP_ADDIU, 3, 0, 16'h0002));
        prog.push_back(r_op(`CORE_FN_ADDU, 4, 2, 3));
        prog.push_back(r_op(`CORE_FN_SUBU, 5, 3, 2));
        prog.push_back(r_op(`CORE_FN_AND, 6, 1, 2));
        prog.push_back(r_op(`CORE_FN_OR, 7, 1, 3));
        prog.push_back(r_op(`CORE_FN_XOR, 8, 6, 7));
        prog.push_back(r_op(`CORE_FN_SLT, 9, 2, 3));
        prog.push_back(r_op(`CORE_FN_SLTU, 10, 2, 3));
        // writes to r0 are dropped
        prog.push_back(i_op(`CORE_OP_ADDIU, 0, 0, 16'h0005));
        prog.push_back(r_op(`CORE_FN_ADDU, 11, 0, 0));
        prog.push_back(r_op(`CORE_FN_DIV, 0, 2, 3));
        prog.push_back(r_op(`CORE_FN_MFHI, 12, 0, 0));
        prog.push_back(r_op(`CORE_FN_MFLO, 13, 0, 0));
        prog.push_back(r_op(`CORE_FN_DIVU, 0, 2, 3));
        prog.push_back(r_op(`CORE_FN_DIV, 0, 5, 2));
        prog.push_back(r_op(`CORE_FN_MFLO, 14, 0, 0));
        prog.push_back(r_op(`CORE_FN_DIV, 0, 1, 0));
        prog.push_back(r_op(`CORE_FN_MFHI, 15, 0, 0));
        prog.push_back(r_op(`CORE_FN_DIVU, 0, 3, 0));
        prog.push_back(r_op(`CORE_FN_MFLO, 16, 0, 0));
        prog.push_back(i_op(`CORE_OP_LUI, 17, 0, 16'h8000));
        prog.push_back(i_op(`CORE_OP_ADDIU, 18, 0, 16'hffff));
        prog.push_back(r_op(`CORE_FN_DIV, 0, 17, 18));
        prog.push_back(r_op(`CORE_FN_MFHI, 19, 0, 0));
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Something failed");
        $fatal(1, "wait limit reached");
    endtask

    // four-phase issue, starts and ends on a rising edge
    task automatic issue(input core_pkg::instr_u word);
        int waited;
        int hold;
        waited = 0;
        hold   = $urandom_range(2, 0);
        instr_req <= 1'b1;
        instr     <= word;
        @(negedge clk);
        while (!instr_ack) begin
            if (waited == WAIT_LIMIT) begin
                stop_on_timeout("instr_ack_o to rise");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        // a slow source keeps req up for a while after the ack
        repeat (hold) @(posedge clk);
        instr_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (instr_ack) begin
            if (waited == WAIT_LIMIT) begin
                stop_on_timeout("instr_ack_o to fall");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (UUT.u_props.pending != 0) begin
            if (waited == WAIT_LIMIT) begin
                stop_on_timeout("the last instruction to retire");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(61213));
        rst       = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // idle with no request
        repeat (4) @(posedge clk);
        load_program();
        foreach (prog[k]) begin
            issue(prog[k]);
        end
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            issue(random_instr());
        end
        wait_drain();
        if (UUT.u_props.fail_seen) begin
            $display("Something failed");
            $fatal(1, "a check failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* bench/core_props.sv */
//////////////////////////////
// shadow model and checks, bound into core_top
//////////////////////////////
`include "core_cfg.svh"

module core_props (
    input logic              clk,
    input logic              rst,
    input logic              instr_req_i,
    input core_pkg::instr_u  instr_i,
    input logic              instr_ack_i,
    input logic              ex_busy_i,
    input core_pkg::retire_t retire_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int EXP_DEPTH = 16;

    logic                  fail_seen;
    logic [`CORE_XLEN-1:0] gpr [32];
    logic [`CORE_XLEN-1:0] hi_m;
    logic [`CORE_XLEN-1:0] lo_m;
    core_pkg::retire_t     exp_mem [EXP_DEPTH];
    int                    wr_ptr;
    int                    rd_ptr;
    int                    pending;
    core_pkg::retire_t     nxt;
    core_pkg::retire_t     head;
    logic                  ack_div;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] q;
    logic [`CORE_XLEN-1:0] r;

    initial begin
        fail_seen = 1'b0;
    end

    assign pending  = wr_ptr - rd_ptr;
    assign head     = exp_mem[rd_ptr % EXP_DEPTH];
    assign ack_div  = (instr_i.r.opcode == `CORE_OP_SPECIAL) &&
                      (instr_i.r.funct == `CORE_FN_DIV || instr_i.r.funct == `CORE_FN_DIVU);

    // architectural result of the word on the port
    always_comb begin
        a         = gpr[instr_i.r.rs];
        b         = gpr[instr_i.r.rt];
        q         = '1;
        r         = a;
        nxt       = '0;
        nxt.valid = 1'b1;
        nxt.hi    = hi_m;
        nxt.lo    = lo_m;
        case (instr_i.r.opcode)
            `CORE_OP_SPECIAL: begin
                nxt.wr_en   = 1'b1;
                nxt.wr_addr = instr_i.r.rd;
                case (instr_i.r.funct)
                    `CORE_FN_ADDU: nxt.wr_data = a + b;
                    `CORE_FN_SUBU: nxt.wr_data = a - b;
                    `CORE_FN_AND:  nxt.wr_data = a & b;
                    `CORE_FN_OR:   nxt.wr_data = a | b;
                    `CORE_FN_XOR:  nxt.wr_data = a ^ b;
                    `CORE_FN_SLT:  nxt.wr_data = ($signed(a) < $signed(b)) ? 1 : 0;
                    `CORE_FN_SLTU: nxt.wr_data = (a < b) ? 1 : 0;
                    `CORE_FN_MFHI: nxt.wr_data = hi_m;
                    `CORE_FN_MFLO: nxt.wr_data = lo_m;
                    `CORE_FN_DIV, `CORE_FN_DIVU: begin
                        nxt.wr_en = 1'b0;
                        // zero divisor keeps the defaults above
                        if (b != '0) begin
                            if (instr_i.r.funct == `CORE_FN_DIVU) begin
                                q = a / b;
                                r = a % b;
                            end else if (a == 32'h8000_0000 && b == '1) begin
                                q = a;
                                r = '0;
                            end else begin
                                q = $signed(a) / $signed(b);
                                r = $signed(a) % $signed(b);
                            end
                        end
                        nxt.hi = r;
                        nxt.lo = q;
                    end
                    default: nxt.wr_en = 1'b0;
                endcase
            end
            `CORE_OP_ADDIU: begin
                nxt.wr_en   = 1'b1;
                nxt.wr_addr = instr_i.i.rt;
                nxt.wr_data = a + {{16{instr_i.i.imm16[15]}}, instr_i.i.imm16};
            end
            `CORE_OP_ORI: begin
                nxt.wr_en   = 1'b1;
                nxt.wr_addr = instr_i.i.rt;
                nxt.wr_data = a | {16'h0000, instr_i.i.imm16};
            end
            `CORE_OP_LUI: begin
                nxt.wr_en   = 1'b1;
                nxt.wr_addr = instr_i.i.rt;
                nxt.wr_data = {instr_i.i.imm16, 16'h0000};
            end
            default: nxt.wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                gpr[k] <= '0;
            end
            hi_m   <= '0;
            lo_m   <= '0;
            wr_ptr <= 0;
            rd_ptr <= 0;
        end else begin
            if (instr_ack_i) begin
                exp_mem[wr_ptr % EXP_DEPTH] <= nxt;
                wr_ptr                      <= wr_ptr + 1;
                hi_m                        <= nxt.hi;
                lo_m                        <= nxt.lo;
                if (nxt.wr_en && nxt.wr_addr != '0) begin
                    gpr[nxt.wr_addr] <= nxt.wr_data;
                end
            end
            if (retire_i.valid) begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) !instr_req_i |-> !instr_ack_i
    ) else begin
        fail_seen = 1'b1;
        $error("ack given without a request");
    end

    a_ack_pulse: assert property (
        @(posedge clk) disable iff (rst) instr_ack_i |=> !instr_ack_i
    ) else begin
        fail_seen = 1'b1;
        $error("ack stayed high for more than one cycle");
    end

    a_no_ack_busy: assert property (
        @(posedge clk) disable iff (rst) ex_busy_i |-> !instr_ack_i
    ) else begin
        fail_seen = 1'b1;
        $error("ack given while a divide is in execute");
    end

    a_alu_latency: assert property (
        @(posedge clk) disable iff (rst) instr_ack_i && !ack_div |-> ##2 retire_i.valid
    ) else begin
        fail_seen = 1'b1;
        $error("ALU instruction did not retire two cycles after its ack");
    end

    a_retire_outstanding: assert property (
        @(posedge clk) disable iff (rst) retire_i.valid |-> pending != 0
    ) else begin
        fail_seen = 1'b1;
        $error("retire seen with no instruction outstanding");
    end

    // one in decode and one in execute at most
    a_in_flight: assert property (
        @(posedge clk) disable iff (rst) retire_i.valid |-> pending <= 2
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH in_flight expected at most 2 actual %0d", $sampled(pending));
    end

    a_wr_en: assert property (
        @(posedge clk) disable iff (rst) retire_i.valid |-> retire_i.wr_en == head.wr_en
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH wr_en expected %b actual %b",
               $sampled(head.wr_en), $sampled(retire_i.wr_en));
    end

    a_wr_addr: assert property (
        @(posedge clk) disable iff (rst)
        retire_i.valid && head.wr_en |-> retire_i.wr_addr == head.wr_addr
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH wr_addr expected %0d actual %0d",
               $sampled(head.wr_addr), $sampled(retire_i.wr_addr));
    end

    a_wr_data: assert property (
        @(posedge clk) disable iff (rst)
        retire_i.valid && head.wr_en |-> retire_i.wr_data == head.wr_data
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH wr_data expected %h actual %h",
               $sampled(head.wr_data), $sampled(retire_i.wr_data));
    end

    a_hi: assert property (
        @(posedge clk) disable iff (rst) retire_i.valid |-> retire_i.hi == head.hi
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH hi expected %h actual %h", $sampled(head.hi), $sampled(retire_i.hi));
    end

    a_lo: assert property (
        @(posedge clk) disable iff (rst) retire_i.valid |-> retire_i.lo == head.lo
    ) else begin
        fail_seen = 1'b1;
        $error("MISMATCH lo expected %h actual %h", $sampled(head.lo), $sampled(retire_i.lo));
    end

endmodule

/* hdl/core_top.sv */
//////////////////////////////
// integer core top level, instruction port in
// and retire port out
//////////////////////////////
`include "core_cfg.svh"

module core_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_req_i,
    input  core_pkg::instr_u  instr_i,
    output logic              instr_ack_o,
    output core_pkg::retire_t retire_o
);

    logic                    dec_valid;
    logic                    ex_valid;
    logic                    ex_busy;
    logic [`CORE_REG_AW-1:0] rs_addr;
    logic [`CORE_REG_AW-1:0] rt_addr;
    logic [`CORE_XLEN-1:0]   rs_data;
    logic [`CORE_XLEN-1:0]   rt_data;
    core_pkg::ex_pkt_t       ex_pkt;
    core_pkg::div_req_t      div_req;
    logic                    div_start;
    logic                    div_done;
    logic [`CORE_XLEN-1:0]   quotient;
    logic [`CORE_XLEN-1:0]   remainder;

    pipe_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .instr_req_i (instr_req_i),
        .instr_ack_o (instr_ack_o),
        .ex_busy_i   (ex_busy),
        .dec_valid_o (dec_valid),
        .ex_valid_o  (ex_valid)
    );

    decode_stage u_dec (
        .clk       (clk),
        .rst       (rst),
        .instr_i   (instr_i),
        .capture_i (dec_valid),
        .hold_i    (ex_busy),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .fwd_i     (retire_o),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .pkt_o     (ex_pkt)
    );

    reg_file u_rf (
        .clk       (clk),
        .rst       (rst),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wr_i      (retire_o)
    );

    execute_stage u_ex (
        .clk         (clk),
        .rst         (rst),
        .pkt_i       (ex_pkt),
        .valid_i     (ex_valid),
        .busy_o      (ex_busy),
        .div_req_o   (div_req),
        .div_start_o (div_start),
        .div_done_i  (div_done),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .retire_o    (retire_o)
    );

    div_unit u_div (
        .clk         (clk),
        .rst         (rst),
        .req_i       (div_req),
        .start_i     (div_start),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

endmodule

/* hdl/execute_stage.sv */
//////////////////////////////
// ALU, HI/LO and the retire register, drives
// the divider while a divide is in execute
//////////////////////////////
`include "core_cfg.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::ex_pkt_t     pkt_i,
    input  logic                  valid_i,
    output logic                  busy_o,
    output core_pkg::div_req_t    div_req_o,
    output logic                  div_start_o,
    input  logic                  div_done_i,
    input  logic [`CORE_XLEN-1:0] quotient_i,
    input  logic [`CORE_XLEN-1:0] remainder_i,
    output core_pkg::retire_t     retire_o
);

    logic                  is_div;
    logic                  div_finish;
    logic                  fire;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] result;
    logic [`CORE_XLEN-1:0] hi_q;
    logic [`CORE_XLEN-1:0] lo_q;
    logic [`CORE_XLEN-1:0] hi_d;
    logic [`CORE_XLEN-1:0] lo_d;

    assign a = pkt_i.operand_a;
    assign b = pkt_i.operand_b;

    assign is_div     = (pkt_i.op == core_pkg::ALU_DIV) || (pkt_i.op == core_pkg::ALU_DIVU);
    assign div_finish = div_start_o && div_done_i;
    assign busy_o     = valid_i && is_div && !div_finish;
    assign fire       = valid_i && !busy_o;

    // packet is held in decode for the whole divide
    assign div_req_o.is_signed = (pkt_i.op == core_pkg::ALU_DIV);
    assign div_req_o.dividend  = a;
    assign div_req_o.divisor   = b;

    always_comb begin
        case (pkt_i.op)
            core_pkg::ALU_ADD:  result = a + b;
            core_pkg::ALU_SUB:  result = a - b;
            core_pkg::ALU_AND:  result = a & b;
            core_pkg::ALU_OR:   result = a | b;
            core_pkg::ALU_XOR:  result = a ^ b;
            core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, a < b};
            core_pkg::ALU_LUI:  result = b;
            core_pkg::ALU_MFHI: result = hi_q;
            core_pkg::ALU_MFLO: result = lo_q;
            default:            result = '0;
        endcase
    end

    assign hi_d = is_div ? remainder_i : hi_q;
    assign lo_d = is_div ? quotient_i : lo_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_start_o <= 1'b0;
            hi_q        <= '0;
            lo_q        <= '0;
        end else begin
            // wait for done to fall from the previous divide before a new start
            if (valid_i && is_div && !div_start_o && !div_done_i) begin
                div_start_o <= 1'b1;
            end else if (div_finish) begin
                div_start_o <= 1'b0;
            end
            if (fire) begin
                hi_q <= hi_d;
                lo_q <= lo_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_o.valid <= 1'b0;
        end else begin
            retire_o.valid <= fire;
            if (fire) begin
                retire_o.wr_en   <= pkt_i.wr_en;
                retire_o.wr_addr <= pkt_i.wr_addr;
                retire_o.wr_data <= result;
                retire_o.hi      <= hi_d;
                retire_o.lo      <= lo_d;
            end
        end
    end

endmodule

/* hdl/reg_file.sv */
//////////////////////////////
// general purpose registers, written from
// the retire record
//////////////////////////////
`include "core_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CORE_REG_AW-1:0] rs_addr_i,
    input  logic [`CORE_REG_AW-1:0] rt_addr_i,
    output logic [`CORE_XLEN-1:0]   rs_data_o,
    output logic [`CORE_XLEN-1:0]   rt_data_o,
    input  core_pkg::retire_t       wr_i
);

    localparam int NREGS = 1 << `CORE_REG_AW;

    logic [`CORE_XLEN-1:0] regs [NREGS];
    logic                  wr_fire;

    // r0 is cleared on reset and never written
    assign wr_fire = wr_i.valid && wr_i.wr_en && (wr_i.wr_addr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_fire) begin
            regs[wr_i.wr_addr] <= wr_i.wr_data;
        end
    end

    // write-through
    assign rs_data_o = (wr_fire && wr_i.wr_addr == rs_addr_i) ? wr_i.wr_data : regs[rs_addr_i];
    assign rt_data_o = (wr_fire && wr_i.wr_addr == rt_addr_i) ? wr_i.wr_data : regs[rt_addr_i];

endmodule

/* hdl/decode_stage.sv */
//////////////////////////////
// instruction word to execute packet, operands
// read here with forwarding from retire
//////////////////////////////
`include "core_cfg.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  core_pkg::instr_u        instr_i,
    input  logic                    capture_i,
    input  logic                    hold_i,
    input  logic [`CORE_XLEN-1:0]   rs_data_i,
    input  logic [`CORE_XLEN-1:0]   rt_data_i,
    input  core_pkg::retire_t       fwd_i,
    output logic [`CORE_REG_AW-1:0] rs_addr_o,
    output logic [`CORE_REG_AW-1:0] rt_addr_o,
    output core_pkg::ex_pkt_t       pkt_o
);

    logic [15:0]           imm;
    logic                  fwd_ok;
    logic [`CORE_XLEN-1:0] rs_val;
    logic [`CORE_XLEN-1:0] rt_val;
    core_pkg::ex_pkt_t     pkt_d;

    // rs and rt sit at the same bits in both layouts
    assign rs_addr_o = instr_i.r.rs;
    assign rt_addr_o = instr_i.r.rt;
    assign imm       = instr_i.i.imm16;

    assign fwd_ok = fwd_i.valid && fwd_i.wr_en && (fwd_i.wr_addr != '0);
    assign rs_val = (fwd_ok && fwd_i.wr_addr == rs_addr_o) ? fwd_i.wr_data : rs_data_i;
    assign rt_val = (fwd_ok && fwd_i.wr_addr == rt_addr_o) ? fwd_i.wr_data : rt_data_i;

    always_comb begin
        pkt_d           = '0;
        pkt_d.op        = core_pkg::ALU_ADD;
        pkt_d.operand_a = rs_val;
        pkt_d.operand_b = rt_val;
        case (instr_i.r.opcode)
            `CORE_OP_SPECIAL: begin
                pkt_d.wr_en   = 1'b1;
                pkt_d.wr_addr = instr_i.r.rd;
                case (instr_i.r.funct)
                    `CORE_FN_ADDU: pkt_d.op = core_pkg::ALU_ADD;
                    `CORE_FN_SUBU: pkt_d.op = core_pkg::ALU_SUB;
                    `CORE_FN_AND:  pkt_d.op = core_pkg::ALU_AND;
                    `CORE_FN_OR:   pkt_d.op = core_pkg::ALU_OR;
                    `CORE_FN_XOR:  pkt_d.op = core_pkg::ALU_XOR;
                    `CORE_FN_SLT:  pkt_d.op = core_pkg::ALU_SLT;
                    `CORE_FN_SLTU: pkt_d.op = core_pkg::ALU_SLTU;
                    `CORE_FN_MFHI: pkt_d.op = core_pkg::ALU_MFHI;
                    `CORE_FN_MFLO: pkt_d.op = core_pkg::ALU_MFLO;
                    `CORE_FN_DIV: begin
                        pkt_d.op    = core_pkg::ALU_DIV;
                        pkt_d.wr_en = 1'b0;
                    end
                    `CORE_FN_DIVU: begin
                        pkt_d.op    = core_pkg::ALU_DIVU;
                        pkt_d.wr_en = 1'b0;
                    end
                    default: pkt_d.wr_en = 1'b0;
                endcase
            end
            `CORE_OP_ADDIU: begin
                pkt_d.wr_en     = 1'b1;
                pkt_d.wr_addr   = instr_i.i.rt;
                pkt_d.operand_b = {{(`CORE_XLEN-16){imm[15]}}, imm};
            end
            `CORE_OP_ORI: begin
                pkt_d.op        = core_pkg::ALU_OR;
                pkt_d.wr_en     = 1'b1;
                pkt_d.wr_addr   = instr_i.i.rt;
                pkt_d.operand_b = {{(`CORE_XLEN-16){1'b0}}, imm};
            end
            `CORE_OP_LUI: begin
                pkt_d.op        = core_pkg::ALU_LUI;
                pkt_d.wr_en     = 1'b1;
                pkt_d.wr_addr   = instr_i.i.rt;
                pkt_d.operand_b = {imm, {(`CORE_XLEN-16){1'b0}}};
            end
            default: pkt_d.wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_o <= '0;
        end else if (capture_i && !hold_i) begin
            pkt_o <= pkt_d;
        end
    end

endmodule

/* hdl/pipe_control.sv */
//////////////////////////////
// issue handshake and slot valid bits, stalls
// while execute reports busy
//////////////////////////////
module pipe_control (
    input  logic clk,
    input  logic rst,
    input  logic instr_req_i,
    output logic instr_ack_o,
    input  logic ex_busy_i,
    output logic dec_valid_o,
    output logic ex_valid_o
);

    logic armed_q;
    logic ex_valid_q;
    logic capture;

    // the word sits in decode only during the ack cycle,
    // so a capture needs execute free or finishing this cycle
    assign capture = instr_req_i && armed_q && !ex_busy_i;

    assign instr_ack_o = capture;
    assign dec_valid_o = capture;
    assign ex_valid_o  = ex_valid_q;

    // armed means req was seen low since the last ack
    always_ff @(posedge clk) begin
        if (rst) begin
            armed_q <= 1'b1;
        end else if (capture) begin
            armed_q <= 1'b0;
        end else if (!instr_req_i) begin
            armed_q <= 1'b1;
        end
    end

    // a busy divide keeps its slot, anything else leaves after one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= capture || (ex_valid_q && ex_busy_i);
        end
    end

endmodule

/* div/div_unit.sv */
//////////////////////////////
// iterative restoring divider, one quotient bit
// per cycle, four-phase start/done
//////////////////////////////
`include "core_cfg.svh"

module div_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::div_req_t    req_i,
    input  logic                  start_i,
    output logic                  done_o,
    output logic [`CORE_XLEN-1:0] quotient_o,
    output logic [`CORE_XLEN-1:0] remainder_o
);

    localparam int CW = $clog2(`CORE_DIV_STEPS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FIX,
        S_DONE
    } state_e;

    state_e                state_q;
    logic [CW-1:0]         count_q;
    logic [`CORE_XLEN-1:0] q_q;
    logic [`CORE_XLEN-1:0] r_q;
    logic [`CORE_XLEN-1:0] d_q;
    logic [`CORE_XLEN-1:0] dividend_q;
    logic                  neg_q_q;
    logic                  neg_r_q;
    logic                  zero_q;
    logic                  a_neg;
    logic                  b_neg;
    logic [`CORE_XLEN:0]   trial;
    logic [`CORE_XLEN:0]   diff;

    assign a_neg = req_i.is_signed && req_i.dividend[`CORE_XLEN-1];
    assign b_neg = req_i.is_signed && req_i.divisor[`CORE_XLEN-1];

    // borrow out of diff means the trial remainder is below the divisor
    assign trial = {r_q, q_q[`CORE_XLEN-1]};
    assign diff  = trial - {1'b0, d_q};

    assign done_o = (state_q == S_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: if (start_i) state_q <= S_RUN;
                S_RUN:  if (count_q == CW'(`CORE_DIV_STEPS - 1)) state_q <= S_FIX;
                S_FIX:  state_q <= S_DONE;
                S_DONE: if (!start_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                count_q    <= '0;
                r_q        <= '0;
                q_q        <= a_neg ? -req_i.dividend : req_i.dividend;
                d_q        <= b_neg ? -req_i.divisor : req_i.divisor;
                dividend_q <= req_i.dividend;
                neg_q_q    <= a_neg ^ b_neg;
                neg_r_q    <= a_neg;
                zero_q     <= (req_i.divisor == '0);
            end
            S_RUN: begin
                count_q <= count_q + 1'b1;
                r_q     <= diff[`CORE_XLEN] ? trial[`CORE_XLEN-1:0] : diff[`CORE_XLEN-1:0];
                q_q     <= {q_q[`CORE_XLEN-2:0], ~diff[`CORE_XLEN]};
            end
            S_FIX: begin
                // divide by zero gives all ones and leaves the dividend as remainder
                quotient_o  <= zero_q ? '1 : (neg_q_q ? -q_q : q_q);
                remainder_o <= zero_q ? dividend_q : (neg_r_q ? -r_q : r_q);
            end
            default: begin
            end
        endcase
    end

endmodule

/* common/core_pkg.sv */
//////////////////////////////
// instruction word, ALU ops and the records passed
// between pipeline stages
//////////////////////////////
`include "core_cfg.svh"

package core_pkg;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [`CORE_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [15:0]             imm16;
    } instr_i_t;

    // one word, two field layouts
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_DIV,
        ALU_DIVU,
        ALU_MFHI,
        ALU_MFLO
    } alu_op_e;

    typedef struct packed {
        alu_op_e                 op;
        logic [`CORE_XLEN-1:0]   operand_a;
        logic [`CORE_XLEN-1:0]   operand_b;
        logic                    wr_en;
        logic [`CORE_REG_AW-1:0] wr_addr;
    } ex_pkt_t;

    typedef struct packed {
        logic                    valid;
        logic                    wr_en;
        logic [`CORE_REG_AW-1:0] wr_addr;
        logic [`CORE_XLEN-1:0]   wr_data;
        logic [`CORE_XLEN-1:0]   hi;
        logic [`CORE_XLEN-1:0]   lo;
    } retire_t;

    typedef struct packed {
        logic                  is_signed;
        logic [`CORE_XLEN-1:0] dividend;
        logic [`CORE_XLEN-1:0] divisor;
    } div_req_t;

endpackage

/* common/core_cfg.svh */
//////////////////////////////
// widths and instruction codes of the integer core
//////////////////////////////
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_XLEN       32
`define CORE_REG_AW     5
`define CORE_DIV_STEPS  32

// major opcodes
`define CORE_OP_SPECIAL 6'h00
`define CORE_OP_ADDIU   6'h09
`define CORE_OP_ORI     6'h0d
`define CORE_OP_LUI     6'h0f

// funct field of SPECIAL
`define CORE_FN_MFHI    6'h10
`define CORE_FN_MFLO    6'h12
`define CORE_FN_DIV     6'h1a
`define CORE_FN_DIVU    6'h1b
`define CORE_FN_ADDU    6'h21
`define CORE_FN_SUBU    6'h23
`define CORE_FN_AND     6'h24
`define CORE_FN_OR      6'h25
`define CORE_FN_XOR     6'h26
`define CORE_FN_SLT     6'h2a
`define CORE_FN_SLTU    6'h2b

`endif
